// ==== common/mod_pkg.sv ====
package mod_pkg;

  // Word geometry.
  localparam int WORD_W     = 300;
  localparam int CHUNK_W    = 6;
  localparam int NUM_CHUNKS = WORD_W / CHUNK_W;

  // Modulus and the widths that follow from it.
  localparam int MODULUS = 107;
  localparam int RES_W   = 7;
  localparam int TAG_W   = 8;

  // One request from the source.
  typedef struct packed {
    logic [WORD_W-1:0] word;
    logic [TAG_W-1:0]  tag;
  } in_req_t;

  // One result for the sink.
  typedef struct packed {
    logic [RES_W-1:0] residue;
    logic [TAG_W-1:0] tag;
  } res_rec_t;

  // Weight of chunk k is 2^(CHUNK_W*k) mod MODULUS.
  // Walked one chunk at a time so the value never grows past 32 bits.
  function automatic int chunk_weight(input int k);
    int w;
    w = 1;
    for (int i = 0; i < k; i++)
      w = (w * (2 ** CHUNK_W)) % MODULUS;
    return w;
  endfunction

endpackage

// ==== rtl/credit_fifo.sv ====
`timescale 1ns/1ns

module credit_fifo #(
  parameter type entry_t = logic,
  parameter int  DEPTH   = 2
) (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   push,
  input  entry_t push_data,
  input  logic   pop,
  output entry_t head,
  output logic   not_empty,
  output logic   credit
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  entry_t        mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          do_pop;

  assign not_empty = (count != '0);
  assign do_pop    = pop && not_empty;
  assign head      = mem[rd_ptr];
  assign credit    = do_pop; // One credit back per entry removed.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + CW'(push) - CW'(do_pop);
    end
  end

  // Producer never pushes without a credit, so no full check here.
  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= push_data;
  end

endmodule

// ==== reducer/residue_lane.sv ====
`timescale 1ns/1ns

module residue_lane import mod_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  in_req_t  in_req,
  output logic     out_valid,
  output res_rec_t out_res
);

  localparam int TBL_N   = 2 ** CHUNK_W;
  localparam int GRP     = 5;              // Chunks per first-level adder.
  localparam int NUM_GRP = NUM_CHUNKS / GRP;
  localparam int GRP_W   = 10;             // 5 * 106 fits.
  localparam int SUM_W   = 13;             // 50 * 106 fits.
  localparam int F1_W    = 11;
  localparam int F2_W    = 9;
  localparam int F3_W    = 8;
  localparam int FOLD    = (2 ** RES_W) % MODULUS; // 128 mod 107 = 21.

  // Table of (v * weight) mod MODULUS for every chunk value v.
  function automatic logic [TBL_N*RES_W-1:0] chunk_table(input int k);
    logic [TBL_N*RES_W-1:0] tbl;
    int w;
    w   = chunk_weight(k);
    tbl = '0;
    for (int v = 0; v < TBL_N; v++)
      tbl[v*RES_W +: RES_W] = RES_W'((v * w) % MODULUS);
    return tbl;
  endfunction

  logic [RES_W-1:0] part_d [NUM_CHUNKS];
  logic [RES_W-1:0] part_q [NUM_CHUNKS];
  logic [GRP_W-1:0] grp_sum [NUM_GRP];
  logic [SUM_W-1:0] total;
  logic [F1_W-1:0]  fold1;
  logic [F1_W-1:0]  fold1_q;
  logic [F2_W-1:0]  fold2;
  logic [F3_W-1:0]  fold3;
  logic [RES_W-1:0] residue;
  logic [TAG_W-1:0] tag1;
  logic [TAG_W-1:0] tag2;
  logic             v1;
  logic             v2;

  // Stage 1 lookups.
  for (genvar k = 0; k < NUM_CHUNKS; k++)
  begin : g_chunk
    localparam logic [TBL_N*RES_W-1:0] TBL = chunk_table(k);
    assign part_d[k] = TBL[in_req.word[k*CHUNK_W +: CHUNK_W] * RES_W +: RES_W];
  end

  // Stage 2 adder tree, then fold the bits above 2^7.
  always_comb
  begin
    for (int g = 0; g < NUM_GRP; g++)
    begin
      grp_sum[g] = '0;
      for (int j = 0; j < GRP; j++)
        grp_sum[g] = grp_sum[g] + GRP_W'(part_q[g*GRP + j]);
    end
    total = '0;
    for (int g = 0; g < NUM_GRP; g++)
      total = total + SUM_W'(grp_sum[g]);
    fold1 = F1_W'(total[RES_W-1:0]) + F1_W'(FOLD * total[SUM_W-1:RES_W]);
  end

  // Stage 3 folds twice more; one subtraction then suffices.
  always_comb
  begin
    fold2   = F2_W'(fold1_q[RES_W-1:0]) + F2_W'(FOLD * fold1_q[F1_W-1:RES_W]);
    fold3   = F3_W'(fold2[RES_W-1:0]) + F3_W'(FOLD * fold2[F2_W-1:RES_W]);
    residue = (fold3 >= F3_W'(MODULUS)) ? RES_W'(fold3 - F3_W'(MODULUS)) : RES_W'(fold3);
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      v1        <= 1'b0;
      v2        <= 1'b0;
      out_valid <= 1'b0;
    end
    else
    begin
      v1        <= in_valid;
      v2        <= v1;
      out_valid <= v2;
    end
  end

  always_ff @(posedge clk)
  begin
    part_q          <= part_d;
    tag1            <= in_req.tag;
    fold1_q         <= fold1;
    tag2            <= tag1;
    out_res.residue <= residue;
    out_res.tag     <= tag2;
  end

endmodule

// ==== rtl/word_dispatch.sv ====
`timescale 1ns/1ns

module word_dispatch import mod_pkg::*; #(
  parameter int LANES      = 4,
  parameter int IN_CREDITS = 4,
  parameter int LANE_DEPTH = 2
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  in_req_t          in_req,
  output logic             in_credit,
  output logic [LANES-1:0] lane_valid,
  output in_req_t          lane_req [LANES],
  input  logic [LANES-1:0] lane_credit
);

  localparam int PW  = (LANES > 1) ? $clog2(LANES) : 1;
  localparam int LCW = $clog2(LANE_DEPTH + 1);

  in_req_t        head;
  logic           not_empty;
  logic           issue;
  logic [PW-1:0]  rr;
  logic [LCW-1:0] lane_cnt [LANES];

  // Input buffer; its pop credit goes straight back to the source.
  credit_fifo #(
    .entry_t (in_req_t),
    .DEPTH   (IN_CREDITS)
  ) u_in_buf (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (in_valid),
    .push_data (in_req),
    .pop       (issue),
    .head      (head),
    .not_empty (not_empty),
    .credit    (in_credit)
  );

  // Strict round robin, so the collector can drain in the same order.
  assign issue = not_empty && (lane_cnt[rr] != '0);

  for (genvar k = 0; k < LANES; k++)
  begin : g_lane
    assign lane_valid[k] = issue && (rr == PW'(k));
    assign lane_req[k]   = head;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rr <= '0;
      for (int k = 0; k < LANES; k++)
        lane_cnt[k] <= LCW'(LANE_DEPTH);
    end
    else
    begin
      if (issue)
        rr <= (rr == PW'(LANES - 1)) ? '0 : rr + 1'b1;
      for (int k = 0; k < LANES; k++)
        lane_cnt[k] <= lane_cnt[k] + LCW'(lane_credit[k]) - LCW'(lane_valid[k]);
    end
  end

endmodule

// ==== rtl/result_collect.sv ====
`timescale 1ns/1ns

module result_collect import mod_pkg::*; #(
  parameter int LANES       = 4,
  parameter int LANE_DEPTH  = 2,
  parameter int OUT_CREDITS = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [LANES-1:0] res_valid,
  input  res_rec_t         res [LANES],
  output logic [LANES-1:0] lane_credit,
  output logic             out_valid,
  output res_rec_t         out_res,
  input  logic             out_credit
);

  localparam int PW  = (LANES > 1) ? $clog2(LANES) : 1;
  localparam int OCW = $clog2(OUT_CREDITS + 1);

  res_rec_t       heads [LANES];
  logic [LANES-1:0] not_empty;
  logic [LANES-1:0] pop_sel;
  logic [PW-1:0]  rr;
  logic [OCW-1:0] out_cnt;
  logic           pop;

  // One buffer per lane. Space is reserved by the dispatcher's lane credits.
  for (genvar k = 0; k < LANES; k++)
  begin : g_buf
    credit_fifo #(
      .entry_t (res_rec_t),
      .DEPTH   (LANE_DEPTH)
    ) u_res_buf (
      .clk       (clk),
      .rst_n     (rst_n),
      .push      (res_valid[k]),
      .push_data (res[k]),
      .pop       (pop_sel[k]),
      .head      (heads[k]),
      .not_empty (not_empty[k]),
      .credit    (lane_credit[k])
    );

    assign pop_sel[k] = pop && (rr == PW'(k));
  end

  // Wait on the lane whose turn it is, even if another one is ready.
  assign pop = not_empty[rr] && (out_cnt != '0);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rr        <= '0;
      out_cnt   <= OCW'(OUT_CREDITS);
      out_valid <= 1'b0;
    end
    else
    begin
      if (pop)
        rr <= (rr == PW'(LANES - 1)) ? '0 : rr + 1'b1;
      out_cnt   <= out_cnt + OCW'(out_credit) - OCW'(pop); // Credit spent at pop.
      out_valid <= pop;
    end
  end

  always_ff @(posedge clk)
  begin
    if (pop)
      out_res <= heads[rr];
  end

endmodule

// ==== rtl/mod_reduce_top.sv ====
`timescale 1ns/1ns

module mod_reduce_top import mod_pkg::*; #(
  parameter int LANES       = 4,
  parameter int IN_CREDITS  = 4,
  parameter int LANE_DEPTH  = 2,
  parameter int OUT_CREDITS = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  in_req_t  in_req,
  output logic     in_credit,
  output logic     out_valid,
  output res_rec_t out_res,
  input  logic     out_credit
);

  logic [LANES-1:0] lane_valid;
  in_req_t          lane_req [LANES];
  logic [LANES-1:0] lane_credit;
  logic [LANES-1:0] res_valid;
  res_rec_t         res [LANES];

  word_dispatch #(
    .LANES      (LANES),
    .IN_CREDITS (IN_CREDITS),
    .LANE_DEPTH (LANE_DEPTH)
  ) u_dispatch (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_req      (in_req),
    .in_credit   (in_credit),
    .lane_valid  (lane_valid),
    .lane_req    (lane_req),
    .lane_credit (lane_credit)
  );

  for (genvar k = 0; k < LANES; k++)
  begin : g_lane
    residue_lane u_lane (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (lane_valid[k]),
      .in_req    (lane_req[k]),
      .out_valid (res_valid[k]),
      .out_res   (res[k])
    );
  end

  result_collect #(
    .LANES       (LANES),
    .LANE_DEPTH  (LANE_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) u_collect (
    .clk         (clk),
    .rst_n       (rst_n),
    .res_valid   (res_valid),
    .res         (res),
    .lane_credit (lane_credit),
    .out_valid   (out_valid),
    .out_res     (out_res),
    .out_credit  (out_credit)
  );

endmodule

// ==== sim/tb_mod_reduce.sv ====
`timescale 1ns/1ns

module tb_mod_reduce import mod_pkg::*; ();

  localparam int LANES       = 4;
  localparam int IN_CREDITS  = 4;
  localparam int LANE_DEPTH  = 2;
  localparam int OUT_CREDITS = 4;
  localparam int NUM_VEC     = 30;
  localparam int VEC_W       = WORD_W + TAG_W + 8; // Word, tag, residue.
  localparam int STALL       = 80;                  // Cycles the sink holds back credit.

  logic     clk = 1'b0;
  logic     rst_n;
  logic     in_valid;
  in_req_t  in_req;
  logic     in_credit;
  logic     out_valid;
  res_rec_t out_res;
  logic     out_credit;

  logic [VEC_W-1:0] golden [NUM_VEC];
  logic [15:0]      pending_q [$]; // Tag and residue still owed a result.
  logic [31:0]      rng;
  int               src_credits;
  int               out_pulses;
  int               grants;
  int               owed;          // Results taken by the sink, credit not yet returned.
  int               mismatches;
  int               failures;
  bit               timed_out;

  mod_reduce_top #(
    .LANES       (LANES),
    .IN_CREDITS  (IN_CREDITS),
    .LANE_DEPTH  (LANE_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_req     (in_req),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_res    (out_res),
    .out_credit (out_credit)
  );

  initial
  begin
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_idle(input string where);
    if (out_valid !== 1'b0 || in_credit !== 1'b0)
    begin
      $display("mismatch at %0t: out_valid %b and in_credit %b should be low %s",
               $time, out_valid, in_credit, where);
      mismatches++;
    end
  endtask

  // Mode 0 random source and sink, 1 sink stalls first, 2 full rate.
  task automatic run_batch(input int mode, input int limit);
    int          sent;
    int          got;
    int          cycles;
    bit          send;
    bit          grant;
    logic [15:0] want;
    sent   = 0;
    got    = 0;
    cycles = 0;
    while ((got < NUM_VEC || owed > 0) && !timed_out)
    begin
      @(posedge clk);
      rng   = lcg_next(rng);
      send  = (sent < NUM_VEC) && (src_credits > 0) && (mode != 0 || rng[31]);
      grant = (owed > 0) && (mode == 2 || (mode == 1 && cycles >= STALL) ||
              (mode == 0 && rng[29]));
      in_valid   <= send;
      out_credit <= grant;
      if (send)
      begin
        in_req.word <= golden[sent][VEC_W-1 -: WORD_W];
        in_req.tag  <= golden[sent][15:8];
        pending_q.push_back(golden[sent][15:0]);
        src_credits--;
        sent++;
      end
      if (grant)
      begin
        grants++;
        owed--;
      end

      @(negedge clk);
      if (in_credit)
        src_credits++;
      // By now the stall has backed up through every buffer.
      if (mode == 1 && cycles >= STALL / 2 && cycles < STALL && in_credit)
      begin
        $display("input credit returned at %0t while the sink was stalled", $time);
        failures++;
      end
      if (out_valid)
      begin
        out_pulses++;
        owed++;
        if (out_pulses > OUT_CREDITS + grants)
        begin
          $display("output sent %0d results with only %0d credits at %0t",
                   out_pulses, OUT_CREDITS + grants, $time);
          failures++;
        end
        if (pending_q.size() == 0)
        begin
          $display("unexpected extra result with tag %h at %0t", out_res.tag, $time);
          failures++;
        end
        else
        begin
          want = pending_q.pop_front();
          got++;
          if ({1'b0, out_res.residue} !== want[7:0])
          begin
            $display("mismatch at %0t: residue for tag %h expected %0d got %0d",
                     $time, want[15:8], want[7:0], out_res.residue);
            mismatches++;
          end
          if (out_res.tag !== want[15:8])
          begin
            $display("mismatch at %0t: tag out of order, expected %h got %h",
                     $time, want[15:8], out_res.tag);
            mismatches++;
          end
        end
      end
      cycles++;
      if (cycles >= limit && (got < NUM_VEC || owed > 0))
      begin
        $display("batch %0d timed out after %0d cycles with %0d of %0d results",
                 mode, cycles, got, NUM_VEC);
        failures++;
        timed_out = 1'b1;
      end
    end

    @(posedge clk);
    in_valid   <= 1'b0;
    out_credit <= 1'b0;
    @(negedge clk);
    if (out_valid || in_credit)
    begin
      $display("unexpected activity at %0t after batch %0d was drained", $time, mode);
      failures++;
    end
    if (!timed_out && src_credits != IN_CREDITS)
    begin
      $display("mismatch at %0t: source credits expected %0d got %0d",
               $time, IN_CREDITS, src_credits);
      mismatches++;
    end
  endtask

  initial
  begin
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_req      = '0;
    out_credit  = 1'b0;
    rng         = 32'hf692_e86f;
    src_credits = IN_CREDITS;
    out_pulses  = 0;
    grants      = 0;
    owed        = 0;
    mismatches  = 0;
    failures    = 0;
    timed_out   = 1'b0;
    $readmemh("sim/golden_vectors.hex", golden);

    for (int i = 0; i < 16; i++)
    begin
      @(negedge clk);
      check_idle("during reset");
    end
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_idle("after reset");

    run_batch(0, 1000);
    if (!timed_out)
      run_batch(1, 1000);
    if (!timed_out)
      run_batch(2, NUM_VEC + 20); // Full rate must keep one result per cycle.

    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// ==== list.f ====
common/mod_pkg.sv
rtl/credit_fifo.sv
reducer/residue_lane.sv
rtl/word_dispatch.sv
rtl/result_collect.sv
rtl/mod_reduce_top.sv
sim/tb_mod_reduce.sv

// ==== Makefile ====
# Verilator flow for the modular reduction engine.
VERILATOR ?= verilator
TOP       ?= tb_mod_reduce
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing -Wno-fatal
LINTFLAGS ?= -Wall
PASS_MSG  ?= ** PASS **

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

# Build, run, and decide pass or fail from the run's own output.
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// ==== sim/golden_vectors.hex ====
// Columns: word as 75 hex digits in groups of five, tag, expected residue mod 107.
// Each line is one 316-bit entry; the underscores only separate the fields.
00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00_00
fffff_fffff_fffff_fffff_fffff_fffff_fffff_fffff_fffff_fffff_fffff_fffff_fffff_fffff_fffff_ff_58
00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_0006b_01_00
00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_0006a_02_6a
00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_0006c_03_01
00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_000d6_04_00
fffff_fffff_fffff_fffff_fffff_fffff_fffff_fffff_fffff_fffff_fffff_fffff_fffff_fffff_fffa7_a5_00
00000_00000_00000_00000_0006b_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_5a_00
00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_06b6b_c3_00
04104_10410_41041_04104_10410_41041_04104_10410_41041_04104_10410_41041_04104_10410_41041_10_69
82082_08208_20820_82082_08208_20820_82082_08208_20820_82082_08208_20820_82082_08208_20820_15_2b
20820_82082_08208_20820_82082_08208_20820_82082_08208_20820_82082_08208_20820_82082_08208_13_5b
00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00001_20_01
00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00040_26_40
00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00080_27_15
00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_02000_00000_00000_35_6a
00000_00000_00000_00000_00000_00000_00000_00000_00000_00040_00000_00000_00000_00000_00000_6a_01
00000_00000_00000_00000_00000_00000_00000_00400_00000_00000_00000_00000_00000_00000_00000_96_0e
04000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_e6_5a
80000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_eb_62
00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_01000_00000_40_1d
00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00010_00000_00000_00000_41_5c
00000_00000_00000_00000_00000_00000_00000_00000_00100_00000_00000_00000_00000_00000_00000_42_0b
00000_00000_10000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_43_0e
00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_003ff_3c_3c
00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_0ffff_7e_33
80000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00000_00001_81_63
00000_00000_10000_00000_00000_00000_00000_00000_00100_00000_00000_00010_00000_01000_00000_99_27
fffff_fffff_fffff_fffff_fffff_fffff_fffff_fffff_fffff_fffff_fffff_fffff_fffff_fffff_ffffe_fe_57
00000_00000_00000_00000_00000_00000_00000_003ff_fffff_fffff_fffff_fffff_fffff_fffff_fffff_77_0d
